// ==== source/eicPkg.sv ====
// shared register map, word types and port structs for the interrupt controller RTL and testbench
`default_nettype none

package eicPkg;

    localparam int wordWidth = 32;
    localparam int addrWidth = 4;

    typedef logic [wordWidth-1:0] regWord_t;

    // register map, unlisted addresses read zero and ignore writes
    typedef enum logic [addrWidth-1:0] {
        regEicr   = 4'd0,  // global enable
        regEimsk  = 4'd1,  // channel mask
        regEifr   = 4'd2,  // pending flags
        regEifrs  = 4'd3,  // flag set, write only
        regEifrc  = 4'd4,  // flag clear, write only
        regEismsk = 4'd5,  // sense modes, two bits per channel
        regEiipr  = 4'd6,  // raw inputs, read only
        regEiacm  = 4'd7   // auto-clear on ack
    } regAddr_t;

    typedef enum logic [1:0] {
        senseLow  = 2'd0,
        senseAny  = 2'd1,
        senseFall = 2'd2,
        senseRise = 2'd3
    } senseMode_t;

    typedef struct packed {
        logic     enable;
        regAddr_t addr;
        regWord_t data;
    } regWrite_t;

    // per-flag write enables and values
    typedef struct packed {
        regWord_t select;
        regWord_t value;
    } flagWrite_t;

    typedef struct packed {
        logic [7:0] level;   // priority level, zero when idle
        logic [5:0] vector;
    } cpuRequest_t;

    typedef struct packed {
        logic       ack;
        logic [5:0] vector;
    } cpuAck_t;

endpackage

`default_nettype wire

// ==== source/eicRegisters.sv ====
// software register file of the interrupt controller, decodes writes and multiplexes reads
`default_nettype none

module eicRegisters #(
    parameter int channelCount = 16,
    parameter int senseCount   = 4
) (
    input  logic               CLK,
    input  logic               RESETn,
    input  eicPkg::regWrite_t  regWr,
    input  eicPkg::regAddr_t   regReadAddr,
    input  eicPkg::regWord_t   flags,
    input  eicPkg::regWord_t   signal,
    output eicPkg::regWord_t   regReadData,
    output eicPkg::regWord_t   enabledMask,
    output eicPkg::regWord_t   senseModes,
    output eicPkg::regWord_t   autoClear,
    output eicPkg::flagWrite_t flagWr,
    output logic               present
);
    import eicPkg::*;

    // ones on every implemented channel
    localparam regWord_t usedMask = {wordWidth{1'b1}} >> (wordWidth - channelCount);

    logic                      enableBit;
    logic [channelCount-1:0]   maskReg;
    logic [2*senseCount-1:0]   senseReg;
    logic [channelCount-1:0]   autoClearReg;

    logic wrEicr;
    logic wrEimsk;
    logic wrEismsk;
    logic wrEiacm;

    assign wrEicr   = regWr.enable && (regWr.addr == regEicr);
    assign wrEimsk  = regWr.enable && (regWr.addr == regEimsk);
    assign wrEismsk = regWr.enable && (regWr.addr == regEismsk);
    assign wrEiacm  = regWr.enable && (regWr.addr == regEiacm);

    always_ff @(posedge CLK) begin
        if (!RESETn) begin
            enableBit    <= 1'b0;
            maskReg      <= '0;
            senseReg     <= '0;
            autoClearReg <= '0;
        end else begin
            if (wrEicr)
                enableBit <= regWr.data[0];
            if (wrEimsk)
                maskReg <= regWr.data[channelCount-1:0];
            if (wrEismsk)
                senseReg <= regWr.data[2*senseCount-1:0];
            if (wrEiacm)
                autoClearReg <= regWr.data[channelCount-1:0];
        end
    end

    // flag bank commands
    always_comb begin
        flagWr = '0;
        if (regWr.enable) begin
            case (regWr.addr)
                regEifr: begin
                    flagWr.select = usedMask;
                    flagWr.value  = regWr.data & usedMask;
                end
                regEifrs: begin
                    flagWr.select = regWr.data & usedMask;
                    flagWr.value  = regWr.data & usedMask;  // selected bits are ones
                end
                regEifrc: begin
                    flagWr.select = regWr.data & usedMask;
                    flagWr.value  = '0;
                end
                default: flagWr = '0;
            endcase
        end
    end

    always_comb begin
        case (regReadAddr)
            regEicr:   regReadData = regWord_t'(enableBit);
            regEimsk:  regReadData = regWord_t'(maskReg);
            regEifr:   regReadData = flags;
            regEismsk: regReadData = regWord_t'(senseReg);
            regEiipr:  regReadData = signal & usedMask;
            regEiacm:  regReadData = regWord_t'(autoClearReg);
            default:   regReadData = '0;  // includes set/clear strobes
        endcase
    end

    assign enabledMask = enableBit ? regWord_t'(maskReg) : '0;
    assign senseModes  = regWord_t'(senseReg);
    assign autoClear   = regWord_t'(autoClearReg);
    assign present     = enableBit;

endmodule

`default_nettype wire

// ==== source/eicSense.sv ====
// input history and sense-mode detection for the low interrupt channels
`default_nettype none

module eicSense #(
    parameter int senseCount = 4
) (
    input  logic                  CLK,
    input  logic                  RESETn,
    input  logic [senseCount-1:0] signalIn,
    input  eicPkg::regWord_t      senseModes,
    output logic [senseCount-1:0] sensed
);
    import eicPkg::*;

    typedef enum logic [1:0] {
        init0,
        init1,
        work
    } startState_t;

    startState_t startState;

    logic [senseCount-1:0] prevSample;
    logic [senseCount-1:0] curSample;

    // detection held off until history is filled
    always_ff @(posedge CLK) begin
        if (!RESETn)
            startState <= init0;
        else begin
            case (startState)
                init0:   startState <= init1;
                init1:   startState <= work;
                default: startState <= work;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        prevSample <= curSample;
        curSample  <= signalIn;
    end

    always_comb begin
        sensed = '0;
        for (int i = 0; i < senseCount; i++) begin
            if (startState == work) begin
                case (senseMode_t'(senseModes[2*i +: 2]))
                    senseLow:  sensed[i] = ~prevSample[i] & ~curSample[i];
                    senseAny:  sensed[i] =  prevSample[i] ^  curSample[i];
                    senseFall: sensed[i] =  prevSample[i] & ~curSample[i];
                    senseRise: sensed[i] = ~prevSample[i] &  curSample[i];
                    default:   sensed[i] = 1'b0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/eicFlagBank.sv ====
// sticky pending flags, merging software writes, ack auto-clear and masked input requests
`default_nettype none

module eicFlagBank #(
    parameter int channelCount = 16
) (
    input  logic               CLK,
    input  logic               RESETn,
    input  eicPkg::regWord_t   flagInputs,
    input  eicPkg::regWord_t   enabledMask,
    input  eicPkg::flagWrite_t flagWr,
    input  eicPkg::regWord_t   autoClear,
    input  eicPkg::cpuAck_t    ack,
    output eicPkg::regWord_t   flags
);
    import eicPkg::*;

    logic [channelCount-1:0] flagReg;

    regWord_t ackHot;
    regWord_t ackClear;
    regWord_t nextFlags;

    assign ackHot = regWord_t'(1) << ack.vector;

    // out of range vectors clear nothing
    assign ackClear = (ack.ack && (int'(ack.vector) < channelCount)) ? (ackHot & autoClear)
                                                                      : '0;

    // ack clear beats software write beats input
    assign nextFlags = ~ackClear & ((flagWr.select & flagWr.value)
                                 | (~flagWr.select & (flags | (flagInputs & enabledMask))));

    always_ff @(posedge CLK) begin
        if (!RESETn)
            flagReg <= '0;
        else
            flagReg <= nextFlags[channelCount-1:0];
    end

    assign flags = regWord_t'(flagReg);

endmodule

`default_nettype wire

// ==== source/eicPriority.sv ====
// picks the highest pending channel and encodes the level and vector for the processor
`default_nettype none

module eicPriority #(
    parameter int channelCount = 16
) (
    input  eicPkg::regWord_t    flags,
    output eicPkg::cpuRequest_t request
);

    // later hits overwrite earlier ones, so the top channel wins
    always_comb begin
        request = '0;
        for (int i = 0; i < channelCount; i++) begin
            if (flags[i]) begin
                request.level  = 8'(i + 1);  // level zero means idle
                request.vector = 6'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/eicCore.sv ====
// top level of the external interrupt controller, connects registers, sense, flags and priority
`default_nettype none

module eicCore #(
    parameter int channelCount = 16,
    parameter int senseCount   = 4
) (
    input  logic                CLK,
    input  logic                RESETn,
    input  eicPkg::regWord_t    signal,       // already synchronized
    input  eicPkg::regWrite_t   regWr,
    input  eicPkg::regAddr_t    regReadAddr,
    input  eicPkg::cpuAck_t     ack,
    output eicPkg::regWord_t    regReadData,
    output eicPkg::cpuRequest_t request,
    output logic                present
);
    import eicPkg::*;

    regWord_t              flags;
    regWord_t              enabledMask;
    regWord_t              senseModes;
    regWord_t              autoClear;
    regWord_t              flagInputs;
    flagWrite_t            flagWr;
    logic [senseCount-1:0] sensed;

    eicRegisters #(
        .channelCount(channelCount),
        .senseCount  (senseCount)
    ) registers0 (
        .CLK        (CLK),
        .RESETn     (RESETn),
        .regWr      (regWr),
        .regReadAddr(regReadAddr),
        .flags      (flags),
        .signal     (signal),
        .regReadData(regReadData),
        .enabledMask(enabledMask),
        .senseModes (senseModes),
        .autoClear  (autoClear),
        .flagWr     (flagWr),
        .present    (present)
    );

    eicSense #(
        .senseCount(senseCount)
    ) sense0 (
        .CLK       (CLK),
        .RESETn    (RESETn),
        .signalIn  (signal[senseCount-1:0]),
        .senseModes(senseModes),
        .sensed    (sensed)
    );

    // sense channels replace the low raw bits
    assign flagInputs = {signal[wordWidth-1:senseCount], sensed};

    eicFlagBank #(
        .channelCount(channelCount)
    ) flagBank0 (
        .CLK        (CLK),
        .RESETn     (RESETn),
        .flagInputs (flagInputs),
        .enabledMask(enabledMask),
        .flagWr     (flagWr),
        .autoClear  (autoClear),
        .ack        (ack),
        .flags      (flags)
    );

    eicPriority #(
        .channelCount(channelCount)
    ) priority0 (
        .flags  (flags),
        .request(request)
    );

endmodule

`default_nettype wire

// ==== verif/eicPriority_assert.sv ====
// concurrent checks on the processor request encoding, bound into every eicPriority instance
`default_nettype none

module eicPriorityAssert #(
    parameter int channelCount = 16
) (
    input eicPkg::regWord_t    flags,
    input eicPkg::cpuRequest_t request
);

    logic sampleClk = 1'b0;

    // rises midway between a falling and the next rising edge of the 100 unit design clock
    always begin
        #25;
        sampleClk = 1'b1;
        #50;
        sampleClk = 1'b0;
        #25;
    end

    idleMatchesFlags: assert property (@(posedge sampleClk) disable iff ($isunknown(flags))
        (request.level == 8'd0) == (flags[channelCount-1:0] == '0))
        else $error("request level and pending flags disagree about idle");

    levelMatchesVector: assert property (@(posedge sampleClk) disable iff ($isunknown(flags))
        (request.level != 8'd0) |-> (request.level == 8'(request.vector) + 8'd1))
        else $error("request level is not vector plus one");

    vectorIsPending: assert property (@(posedge sampleClk) disable iff ($isunknown(flags))
        (request.level != 8'd0) |-> flags[request.vector[4:0]])
        else $error("request vector names a channel that is not pending");

endmodule

bind eicPriority eicPriorityAssert #(.channelCount(channelCount)) priorityAssert0 (
    .flags  (flags),
    .request(request)
);

`default_nettype wire

// ==== verif/eicCoreTb.sv ====
// self-checking testbench for eicCore, random register, input and ack traffic against a cycle model
`default_nettype none

module eicCoreTb;
    import eicPkg::*;

    localparam int       channelCount = 16;
    localparam int       senseCount   = 4;
    localparam int       cycleCount   = 3000;
    localparam regWord_t usedMask     = 32'h0000_ffff;

    logic        CLK = 1'b0;
    logic        RESETn;
    regWord_t    signal;
    regWrite_t   regWr;
    regAddr_t    regReadAddr;
    cpuAck_t     ack;
    regWord_t    regReadData;
    cpuRequest_t request;
    logic        present;

    integer seed       = 61;
    int     checkCount = 0;

    // cycle model of the controller state
    logic                  mEnable;
    regWord_t              mMask;
    regWord_t              mSense;
    regWord_t              mAutoClear;
    regWord_t              mFlags;
    logic [senseCount-1:0] mPrev;
    logic [senseCount-1:0] mCur;
    int                    mStart;  // edges since reset, stops at 2

    eicCore #(
        .channelCount(channelCount),
        .senseCount  (senseCount)
    ) dut0 (
        .CLK        (CLK),
        .RESETn     (RESETn),
        .signal     (signal),
        .regWr      (regWr),
        .regReadAddr(regReadAddr),
        .ack        (ack),
        .regReadData(regReadData),
        .request    (request),
        .present    (present)
    );

    always #50 CLK = ~CLK;

    task automatic checkWord(input string name, input regWord_t actual, input regWord_t expected);
        checkCount++;
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic checkRequest(input string name, input cpuRequest_t actual,
                                input cpuRequest_t expected);
        checkCount++;
        if (actual !== expected) begin
            $display("Error: %s is level 0x%h vector 0x%h, expected level 0x%h vector 0x%h",
                     name, actual.level, actual.vector, expected.level, expected.vector);
            $display("TESTBENCH FAILED");
            $fatal(1, "request mismatch");
        end
    endtask

    function automatic regWord_t expectedRead(input regAddr_t addr);
        case (addr)
            regEicr:   return {31'd0, mEnable};
            regEimsk:  return mMask;
            regEifr:   return mFlags;
            regEismsk: return mSense;
            regEiipr:  return signal & usedMask;
            regEiacm:  return mAutoClear;
            default:   return '0;
        endcase
    endfunction

    // scan from the top, first hit is the winner
    function automatic cpuRequest_t expectedRequest(input regWord_t pending);
        cpuRequest_t req;
        req = '0;
        for (int i = channelCount - 1; i >= 0; i--) begin
            if (pending[i] && req.level == 8'd0) begin
                req.level  = 8'(i + 1);
                req.vector = 6'(i);
            end
        end
        return req;
    endfunction

    task automatic driveRandom(input int cycle);
        int              pick;
        logic [3:0]      lowBits;
        cpuRequest_t     winner;
        lowBits = signal[3:0] ^ (4'($random(seed)) & 4'($random(seed)));  // slow toggling
        signal  = $random(seed) & $random(seed) & $random(seed) & usedMask;
        signal[3:0] = lowBits;
        pick = $random(seed) & 15;
        regWr.enable = (cycle >= 8) && (($random(seed) & 3) == 0);
        regWr.addr   = regAddr_t'(4'(pick < 13 ? pick % 8 : pick));
        regWr.data   = $random(seed);
        if (regWr.addr == regEicr)
            regWr.data[0] = (($random(seed) & 3) != 0);
        ack.ack = (cycle >= 8) && (($random(seed) & 7) == 0);
        winner = expectedRequest(mFlags);
        if (($random(seed) & 1) == 1)
            ack.vector = winner.vector;
        else
            ack.vector = 6'($random(seed) & 31);  // out of range vectors too
        regReadAddr = regAddr_t'(4'(cycle < 8 ? cycle : $random(seed) & 15));
    endtask

    // next state at the coming rising edge, from the inputs just driven
    task automatic advanceModel();
        regWord_t flagIn;
        regWord_t next;
        flagIn = signal;
        for (int i = 0; i < senseCount; i++) begin
            flagIn[i] = 1'b0;
            if (mStart == 2) begin
                case (senseMode_t'(mSense[2*i +: 2]))
                    senseLow:  flagIn[i] = !mPrev[i] && !mCur[i];
                    senseAny:  flagIn[i] = mPrev[i] != mCur[i];
                    senseFall: flagIn[i] = mPrev[i] && !mCur[i];
                    senseRise: flagIn[i] = !mPrev[i] && mCur[i];
                endcase
            end
        end
        next = '0;
        for (int i = 0; i < channelCount; i++) begin
            if (ack.ack && ack.vector == 6'(i) && mAutoClear[i])
                next[i] = 1'b0;
            else if (regWr.enable && regWr.addr == regEifr)
                next[i] = regWr.data[i];
            else if (regWr.enable && regWr.addr == regEifrs && regWr.data[i])
                next[i] = 1'b1;
            else if (regWr.enable && regWr.addr == regEifrc && regWr.data[i])
                next[i] = 1'b0;
            else
                next[i] = mFlags[i] | (flagIn[i] & mMask[i] & mEnable);
        end
        if (regWr.enable) begin
            case (regWr.addr)
                regEicr:   mEnable = regWr.data[0];
                regEimsk:  mMask = regWr.data & usedMask;
                regEismsk: mSense = regWr.data & 32'h0000_00ff;
                regEiacm:  mAutoClear = regWr.data & usedMask;
                default:   ;
            endcase
        end
        mFlags = next;
        mPrev  = mCur;
        mCur   = signal[senseCount-1:0];
        if (mStart < 2)
            mStart++;
    endtask

    initial begin
        int waitCount;
        RESETn      = 1'b0;
        signal      = '0;
        regWr       = '0;
        regReadAddr = regEicr;
        ack         = '0;
        mEnable     = 1'b0;
        mMask       = '0;
        mSense      = '0;
        mAutoClear  = '0;
        mFlags      = '0;
        mPrev       = '0;
        mCur        = '0;
        mStart      = 0;
        repeat (2) @(posedge CLK);
        waitCount = 0;
        @(negedge CLK);
        while (present !== 1'b0 || request !== '0) begin
            if (waitCount >= 4) begin
                $display("Timeout: outputs did not return to idle while reset was held");
                $display("TESTBENCH FAILED");
                $fatal(1, "reset timeout");
            end
            waitCount++;
            @(negedge CLK);
        end
        RESETn = 1'b1;
        for (int cycle = 0; cycle < cycleCount; cycle++) begin
            checkWord("regReadData", regReadData, expectedRead(regReadAddr));
            checkWord("present", regWord_t'(present), {31'd0, mEnable});
            checkRequest("request", request, expectedRequest(mFlags));
            driveRandom(cycle);
            advanceModel();
            @(negedge CLK);
        end
        if (checkCount > 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "no checks were run");
        end
    end

endmodule

`default_nettype wire

// ==== eicCore.f ====
source/eicPkg.sv
source/eicRegisters.sv
source/eicSense.sv
source/eicFlagBank.sv
source/eicPriority.sv
source/eicCore.sv
verif/eicPriority_assert.sv
verif/eicCoreTb.sv

// ==== Makefile ====
SOURCES := $(wildcard source/*.sv verif/*.sv)

obj_dir/VeicCoreTb: eicCore.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module eicCoreTb -f eicCore.f

.PHONY: run clean

run: obj_dir/VeicCoreTb
	./obj_dir/VeicCoreTb

clean:
	rm -rf obj_dir
